// File: hdl/datapath_config.svh
`ifndef DATAPATH_CONFIG_SVH
`define DATAPATH_CONFIG_SVH

// Width of the shared bus and of every register on it.
`define DP_WORD_WIDTH 32

// General-purpose registers R0 to R15.
`define DP_NUM_REGS 16

// Immediate field of the immediate-format instructions.
`define DP_IMM_WIDTH 19

`endif

// File: hdl/datapathPkg.sv
`include "datapath_config.svh"

package datapathPkg;

    typedef logic [`DP_WORD_WIDTH-1:0] word_t;
    typedef logic [$clog2(`DP_NUM_REGS)-1:0] regIdx_t;

    typedef enum logic [4:0] {
        opAdd, opSub, opAnd, opOr, opShl, opShr, opMul,
        opAddi, opAndi, opOri,
        opIn, opOut, opMfhi, opMflo
    } opcode_e;

    // Lowest priority first. The value is the select code of the bus multiplexer.
    typedef enum logic [4:0] {
        srcR0, srcR1, srcR2, srcR3, srcR4, srcR5, srcR6, srcR7,
        srcR8, srcR9, srcR10, srcR11, srcR12, srcR13, srcR14, srcR15,
        srcHi, srcLo, srcZHigh, srcZLow, srcInPort, srcConst
    } busSrc_e;

    typedef logic [srcConst:0] busEnable_t;

    typedef struct packed {
        opcode_e opcode;
        regIdx_t ra;
        regIdx_t rb;
        regIdx_t rc;
        logic [14:0] unused;
    } regFormat_t;

    typedef struct packed {
        opcode_e opcode;
        regIdx_t ra;
        regIdx_t rb;
        logic [`DP_IMM_WIDTH-1:0] imm;
    } immFormat_t;

    typedef union packed {
        regFormat_t regForm;
        immFormat_t immForm;
    } instr_t;

endpackage

// File: hdl/busMux.sv
`include "datapath_config.svh"

module busMux
(
    input  datapathPkg::busEnable_t busEnable,
    input  datapathPkg::word_t      regValues [`DP_NUM_REGS],
    input  datapathPkg::word_t      hi,
    input  datapathPkg::word_t      lo,
    input  datapathPkg::word_t      zHigh,
    input  datapathPkg::word_t      zLow,
    input  datapathPkg::word_t      inPort,
    input  datapathPkg::word_t      constant,
    output datapathPkg::word_t      bus
);

    datapathPkg::busSrc_e srcSel;

    // ------------------------------------------------------------
    // Priority encoder
    // ------------------------------------------------------------

    // Later entries overwrite earlier ones, so the highest enabled source wins.
    // With nothing enabled the constant drives the bus.
    always_comb
    begin
        srcSel = datapathPkg::srcConst;
        for (int i = 0; i <= datapathPkg::srcConst; i++)
        begin
            if (busEnable[i])
            begin
                srcSel = datapathPkg::busSrc_e'(i);
            end
        end
    end

    // ------------------------------------------------------------
    // Bus selector
    // ------------------------------------------------------------

    always_comb
    begin
        case (srcSel)
            datapathPkg::srcHi:     bus = hi;
            datapathPkg::srcLo:     bus = lo;
            datapathPkg::srcZHigh:  bus = zHigh;
            datapathPkg::srcZLow:   bus = zLow;
            datapathPkg::srcInPort: bus = inPort;
            datapathPkg::srcConst:  bus = constant;
            // R0 to R15 share their code with the register number.
            default:                bus = regValues[srcSel[3:0]];
        endcase
    end

    // Two drivers at once means the decoder schedule is broken.
    oneBusDriver: assert final ($onehot0(busEnable))
        else $error("busMux: more than one bus source enabled: %b", busEnable);

endmodule

// File: hdl/instrDecode.sv
`include "datapath_config.svh"

module instrDecode
(
    input  logic                    clock,
    input  logic                    rstN,
    input  logic                    instrValid,
    input  datapathPkg::instr_t     instr,
    output datapathPkg::busEnable_t busEnable,
    output logic                    yLoad,
    output logic                    zLoad,
    output logic                    regLoad,
    output logic                    hiLoad,
    output logic                    loLoad,
    output logic                    outLoad,
    output datapathPkg::regIdx_t    destReg,
    output datapathPkg::opcode_e    aluOp,
    output datapathPkg::word_t      constant,
    output logic                    done
);

    datapathPkg::instr_t instrQ;
    logic [2:0]          stepQ;
    logic                isImm;

    // Step 0 is idle. Steps 1 to 4 are bus cycles of the current instruction.
    always_ff @(posedge clock)
    begin
        if (!rstN)
            stepQ <= 3'd0;
        else if (stepQ == 3'd0)
        begin
            if (instrValid)
                stepQ <= 3'd1;
        end
        else if (done)
            stepQ <= 3'd0;
        else
            stepQ <= stepQ + 3'd1;
    end

    always_ff @(posedge clock)
    begin
        if (instrValid && stepQ == 3'd0)
            instrQ <= instr;
    end

    // ------------------------------------------------------------
    // Instruction fields
    // ------------------------------------------------------------

    // The opcode and ra sit in the same place in both formats.
    assign aluOp   = instrQ.regForm.opcode;
    assign destReg = instrQ.regForm.ra;
    assign isImm   = aluOp inside {datapathPkg::opAddi, datapathPkg::opAndi,
                                   datapathPkg::opOri};
    assign constant = {{(`DP_WORD_WIDTH - `DP_IMM_WIDTH){instrQ.immForm.imm[`DP_IMM_WIDTH-1]}},
                       instrQ.immForm.imm};

    // ------------------------------------------------------------
    // Bus schedule
    // ------------------------------------------------------------

    always_comb
    begin
        busEnable = '0;
        yLoad     = 1'b0;
        zLoad     = 1'b0;
        regLoad   = 1'b0;
        hiLoad    = 1'b0;
        loLoad    = 1'b0;
        outLoad   = 1'b0;
        done      = 1'b0;
        case (aluOp)
            datapathPkg::opIn, datapathPkg::opMfhi, datapathPkg::opMflo:
                if (stepQ == 3'd1)
                begin
                    if (aluOp == datapathPkg::opIn)
                        busEnable[datapathPkg::srcInPort] = 1'b1;
                    else if (aluOp == datapathPkg::opMfhi)
                        busEnable[datapathPkg::srcHi] = 1'b1;
                    else
                        busEnable[datapathPkg::srcLo] = 1'b1;
                    regLoad = 1'b1;
                    done    = 1'b1;
                end
            datapathPkg::opOut:
                if (stepQ == 3'd1)
                begin
                    busEnable[instrQ.regForm.ra] = 1'b1;
                    outLoad = 1'b1;
                    done    = 1'b1;
                end
            datapathPkg::opAdd, datapathPkg::opSub, datapathPkg::opAnd, datapathPkg::opOr,
            datapathPkg::opShl, datapathPkg::opShr, datapathPkg::opMul,
            datapathPkg::opAddi, datapathPkg::opAndi, datapathPkg::opOri:
                case (stepQ)
                    3'd1:
                    begin
                        busEnable[instrQ.regForm.rb] = 1'b1;
                        yLoad = 1'b1;
                    end
                    3'd2:
                    begin
                        if (isImm)
                            busEnable[datapathPkg::srcConst] = 1'b1;
                        else
                            busEnable[instrQ.regForm.rc] = 1'b1;
                        zLoad = 1'b1;
                    end
                    3'd3:
                    begin
                        busEnable[datapathPkg::srcZLow] = 1'b1;
                        if (aluOp == datapathPkg::opMul)
                            loLoad = 1'b1;
                        else
                        begin
                            regLoad = 1'b1;
                            done    = 1'b1;
                        end
                    end
                    3'd4:
                    begin
                        busEnable[datapathPkg::srcZHigh] = 1'b1;
                        hiLoad = 1'b1;
                        done   = 1'b1;
                    end
                    default:
                    begin
                    end
                endcase
            // An unknown opcode retires in one idle bus cycle.
            default:
                done = (stepQ == 3'd1);
        endcase
    end

    // The source holds instrValid only between instructions.
    noStrobeWhileBusy: assert property (@(posedge clock) disable iff (!rstN)
        instrValid |-> stepQ == 3'd0)
        else $error("instrDecode: instrValid while an instruction is in progress");

endmodule

// File: hdl/aluExecute.sv
`include "datapath_config.svh"

module aluExecute
(
    input  logic                 clock,
    input  logic                 rstN,
    input  datapathPkg::word_t   bus,
    input  logic                 yLoad,
    input  logic                 zLoad,
    input  datapathPkg::opcode_e aluOp,
    output datapathPkg::word_t   zHigh,
    output datapathPkg::word_t   zLow
);

    datapathPkg::word_t              yQ;
    logic [2*`DP_WORD_WIDTH-1:0]     zQ;
    logic [2*`DP_WORD_WIDTH-1:0]     result;
    logic signed [2*`DP_WORD_WIDTH-1:0] product;

    always_ff @(posedge clock)
    begin
        if (yLoad)
            yQ <= bus;
    end

    // ------------------------------------------------------------
    // ALU
    // ------------------------------------------------------------

    // Both operands widen to 64 bits with their sign before the multiply.
    assign product = $signed(yQ) * $signed(bus);

    always_comb
    begin
        result = '0;
        case (aluOp)
            datapathPkg::opAdd, datapathPkg::opAddi:
                result[`DP_WORD_WIDTH-1:0] = yQ + bus;
            datapathPkg::opSub:
                result[`DP_WORD_WIDTH-1:0] = yQ - bus;
            datapathPkg::opAnd, datapathPkg::opAndi:
                result[`DP_WORD_WIDTH-1:0] = yQ & bus;
            datapathPkg::opOr, datapathPkg::opOri:
                result[`DP_WORD_WIDTH-1:0] = yQ | bus;
            datapathPkg::opShl:
                result[`DP_WORD_WIDTH-1:0] = yQ << bus[4:0];
            datapathPkg::opShr:
                result[`DP_WORD_WIDTH-1:0] = yQ >> bus[4:0];
            datapathPkg::opMul:
                result = product;
            default:
                result = '0;
        endcase
    end

    // ------------------------------------------------------------
    // Z register
    // ------------------------------------------------------------

    always_ff @(posedge clock)
    begin
        if (!rstN)
            zQ <= '0;
        else if (zLoad)
            zQ <= result;
    end

    assign zHigh = zQ[2*`DP_WORD_WIDTH-1:`DP_WORD_WIDTH];
    assign zLow  = zQ[`DP_WORD_WIDTH-1:0];

endmodule

// File: hdl/resultRegs.sv
`include "datapath_config.svh"

module resultRegs
(
    input  logic                 clock,
    input  logic                 rstN,
    input  datapathPkg::word_t   bus,
    input  logic                 regLoad,
    input  logic                 hiLoad,
    input  logic                 loLoad,
    input  logic                 outLoad,
    input  datapathPkg::regIdx_t destReg,
    output datapathPkg::word_t   regValues [`DP_NUM_REGS],
    output datapathPkg::word_t   hi,
    output datapathPkg::word_t   lo,
    output datapathPkg::word_t   outPort
);

    // ------------------------------------------------------------
    // General registers
    // ------------------------------------------------------------

    always_ff @(posedge clock)
    begin
        if (!rstN)
        begin
            for (int i = 0; i < `DP_NUM_REGS; i++)
            begin
                regValues[i] <= '0;
            end
        end
        else if (regLoad)
            regValues[destReg] <= bus;
    end

    // ------------------------------------------------------------
    // HI, LO and output port
    // ------------------------------------------------------------

    always_ff @(posedge clock)
    begin
        if (!rstN)
        begin
            hi      <= '0;
            lo      <= '0;
            outPort <= '0;
        end
        else
        begin
            if (hiLoad)
                hi <= bus;
            if (loLoad)
                lo <= bus;
            if (outLoad)
                outPort <= bus;
        end
    end

    // One bus word per cycle can land in only one place.
    singleWriter: assert property (@(posedge clock) disable iff (!rstN)
        $onehot0({regLoad, hiLoad, loLoad, outLoad}))
        else $error("resultRegs: more than one load strobe in the same cycle");

endmodule

// File: hdl/datapathTop.sv
`include "datapath_config.svh"

module datapathTop
(
    input  logic                clock,
    input  logic                rstN,
    input  logic                instrValid,
    input  datapathPkg::instr_t instr,
    input  datapathPkg::word_t  inPort,
    output logic                done,
    output datapathPkg::word_t  outPort
);

    datapathPkg::busEnable_t busEnable;
    datapathPkg::word_t      bus;
    datapathPkg::word_t      constant;
    datapathPkg::word_t      zHigh;
    datapathPkg::word_t      zLow;
    datapathPkg::word_t      hi;
    datapathPkg::word_t      lo;
    datapathPkg::word_t      regValues [`DP_NUM_REGS];
    datapathPkg::regIdx_t    destReg;
    datapathPkg::opcode_e    aluOp;
    logic                    yLoad;
    logic                    zLoad;
    logic                    regLoad;
    logic                    hiLoad;
    logic                    loLoad;
    logic                    outLoad;

    instrDecode instrDecode_i
    (
        .clock      (clock),
        .rstN       (rstN),
        .instrValid (instrValid),
        .instr      (instr),
        .busEnable  (busEnable),
        .yLoad      (yLoad),
        .zLoad      (zLoad),
        .regLoad    (regLoad),
        .hiLoad     (hiLoad),
        .loLoad     (loLoad),
        .outLoad    (outLoad),
        .destReg    (destReg),
        .aluOp      (aluOp),
        .constant   (constant),
        .done       (done)
    );

    busMux busMux_i
    (
        .busEnable (busEnable),
        .regValues (regValues),
        .hi        (hi),
        .lo        (lo),
        .zHigh     (zHigh),
        .zLow      (zLow),
        .inPort    (inPort),
        .constant  (constant),
        .bus       (bus)
    );

    aluExecute aluExecute_i
    (
        .clock (clock),
        .rstN  (rstN),
        .bus   (bus),
        .yLoad (yLoad),
        .zLoad (zLoad),
        .aluOp (aluOp),
        .zHigh (zHigh),
        .zLow  (zLow)
    );

    resultRegs resultRegs_i
    (
        .clock     (clock),
        .rstN      (rstN),
        .bus       (bus),
        .regLoad   (regLoad),
        .hiLoad    (hiLoad),
        .loLoad    (loLoad),
        .outLoad   (outLoad),
        .destReg   (destReg),
        .regValues (regValues),
        .hi        (hi),
        .lo        (lo),
        .outPort   (outPort)
    );

endmodule

// File: tb/datapathTb.sv
`include "datapath_config.svh"

module datapathTb;

    localparam int clockPeriod = 100;
    localparam int resetCycles = 10;
    localparam int doneLimit   = 10;
    // In and out, sixteen in and out pairs, twelve ALU pairs, six immediate pairs,
    // and three multiply rounds of seven instructions each.
    localparam int instrCount     = 2 + 2 * 16 + 6 * 2 * 2 + 3 * 2 * 2 + 3 * 7;
    localparam int watchdogCycles = resetCycles + 40 * instrCount;

    logic                clock;
    logic                rstN;
    logic                instrValid;
    datapathPkg::instr_t instr;
    datapathPkg::word_t  inPort;
    logic                done;
    datapathPkg::word_t  outPort;

    datapathPkg::word_t  model [`DP_NUM_REGS];
    datapathPkg::word_t  hiModel;
    datapathPkg::word_t  loModel;

    datapathTop dut_i
    (
        .clock      (clock),
        .rstN       (rstN),
        .instrValid (instrValid),
        .instr      (instr),
        .inPort     (inPort),
        .done       (done),
        .outPort    (outPort)
    );

    initial
    begin
        clock = 1'b0;
        forever
            #(clockPeriod / 2) clock = ~clock;
    end

    initial
    begin
        #(watchdogCycles * clockPeriod);
        $display("Watchdog expired: the tests did not finish within %0d cycles.",
                 watchdogCycles);
        stopRun();
    end

    // ------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------

    task stopRun();
        $display("TESTBENCH FAILED");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task checkWord(input string name, input datapathPkg::word_t expected,
                   input datapathPkg::word_t actual);
        if (actual !== expected)
        begin
            $display("ERROR at %0t: %s expected %h, got %h", $time, name, expected, actual);
            stopRun();
        end
    endtask

    task checkLatency(input int expected, input int actual);
        if (actual != expected)
        begin
            $display("ERROR at %0t: done expected in cycle %0d, came in cycle %0d",
                     $time, expected, actual);
            stopRun();
        end
    endtask

    // Expected ALU result, taken from the instruction set rules.
    function automatic datapathPkg::word_t aluModel(input datapathPkg::opcode_e op,
                                                    input datapathPkg::word_t a,
                                                    input datapathPkg::word_t b);
        case (op)
            datapathPkg::opAdd, datapathPkg::opAddi: return a + b;
            datapathPkg::opSub:                      return a - b;
            datapathPkg::opAnd, datapathPkg::opAndi: return a & b;
            datapathPkg::opOr, datapathPkg::opOri:   return a | b;
            datapathPkg::opShl:                      return a << b[4:0];
            datapathPkg::opShr:                      return a >> b[4:0];
            default:                                 return '0;
        endcase
    endfunction

    // ------------------------------------------------------------
    // Instruction tasks
    // ------------------------------------------------------------

    // Strobes one instruction and counts cycles until done, then steps to the next
    // falling edge so that written values are visible.
    task automatic runInstr(input datapathPkg::instr_t word, input int expectedCycles);
        int cycles;
        instr      = word;
        instrValid = 1'b1;
        @(posedge clock);
        @(negedge clock);
        instrValid = 1'b0;
        cycles     = 1;
        while (done !== 1'b1 && cycles < doneLimit)
        begin
            @(posedge clock);
            @(negedge clock);
            cycles++;
        end
        if (done !== 1'b1)
        begin
            $display("%0t: done never came for opcode %s.", $time, word.regForm.opcode.name());
            stopRun();
        end
        else
            checkLatency(expectedCycles, cycles);
        @(posedge clock);
        @(negedge clock);
    endtask

    task automatic issueIn(input datapathPkg::regIdx_t ra, input datapathPkg::word_t value);
        datapathPkg::instr_t word;
        word = '0;
        word.regForm.opcode = datapathPkg::opIn;
        word.regForm.ra = ra;
        inPort = value;
        runInstr(word, 1);
        model[ra] = value;
    endtask

    task automatic issueOut(input datapathPkg::regIdx_t ra);
        datapathPkg::instr_t word;
        word = '0;
        word.regForm.opcode = datapathPkg::opOut;
        word.regForm.ra = ra;
        runInstr(word, 1);
        checkWord($sformatf("outPort (R%0d)", ra), model[ra], outPort);
    endtask

    task automatic issueAlu(input datapathPkg::opcode_e op, input datapathPkg::regIdx_t ra,
                            input datapathPkg::regIdx_t rb, input datapathPkg::regIdx_t rc);
        datapathPkg::instr_t word;
        datapathPkg::word_t  expected;
        word = '0;
        word.regForm.opcode = op;
        word.regForm.ra = ra;
        word.regForm.rb = rb;
        word.regForm.rc = rc;
        expected = aluModel(op, model[rb], model[rc]);
        runInstr(word, 3);
        model[ra] = expected;
    endtask

    task automatic issueImm(input datapathPkg::opcode_e op, input datapathPkg::regIdx_t ra,
                            input datapathPkg::regIdx_t rb,
                            input logic [`DP_IMM_WIDTH-1:0] imm);
        datapathPkg::instr_t word;
        datapathPkg::word_t  constant;
        datapathPkg::word_t  expected;
        int                  immValue;
        word = '0;
        word.immForm.opcode = op;
        word.immForm.ra = ra;
        word.immForm.rb = rb;
        word.immForm.imm = imm;
        // A set top bit makes the field a negative two's complement number.
        immValue = int'(imm);
        if (imm[`DP_IMM_WIDTH-1])
            immValue = immValue - (1 << `DP_IMM_WIDTH);
        constant = immValue;
        expected = aluModel(op, model[rb], constant);
        runInstr(word, 3);
        model[ra] = expected;
    endtask

    task automatic issueMul(input datapathPkg::regIdx_t rb, input datapathPkg::regIdx_t rc);
        datapathPkg::instr_t word;
        longint a;
        longint b;
        longint product;
        word = '0;
        word.regForm.opcode = datapathPkg::opMul;
        word.regForm.rb = rb;
        word.regForm.rc = rc;
        a = $signed(model[rb]);
        b = $signed(model[rc]);
        product = a * b;
        runInstr(word, 4);
        hiModel = product[63:32];
        loModel = product[31:0];
    endtask

    task automatic issueMove(input datapathPkg::opcode_e op, input datapathPkg::regIdx_t ra);
        datapathPkg::instr_t word;
        word = '0;
        word.regForm.opcode = op;
        word.regForm.ra = ra;
        runInstr(word, 1);
        model[ra] = (op == datapathPkg::opMfhi) ? hiModel : loModel;
    endtask

    function automatic datapathPkg::regIdx_t randomReg();
        return datapathPkg::regIdx_t'($urandom_range(0, `DP_NUM_REGS - 1));
    endfunction

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------

    initial
    begin
        datapathPkg::opcode_e aluOps [6];
        datapathPkg::opcode_e immOps [3];
        datapathPkg::word_t   value;
        datapathPkg::word_t   a;
        datapathPkg::word_t   b;
        datapathPkg::regIdx_t dest;
        logic [`DP_IMM_WIDTH-1:0] imm;

        void'($urandom(32'hc4b2));
        aluOps = '{datapathPkg::opAdd, datapathPkg::opSub, datapathPkg::opAnd,
                   datapathPkg::opOr, datapathPkg::opShl, datapathPkg::opShr};
        immOps = '{datapathPkg::opAddi, datapathPkg::opAndi, datapathPkg::opOri};
        rstN       = 1'b0;
        instrValid = 1'b0;
        instr      = '0;
        inPort     = '0;
        hiModel    = '0;
        loModel    = '0;
        for (int i = 0; i < `DP_NUM_REGS; i++)
            model[i] = '0;
        repeat (resetCycles) @(negedge clock);
        rstN = 1'b1;

        // Idle state after reset, then one in and out pair.
        checkWord("outPort", '0, outPort);
        repeat (3)
        begin
            if (done !== 1'b0)
            begin
                $display("%0t: done went high with no instruction issued.", $time);
                stopRun();
            end
            @(posedge clock);
            @(negedge clock);
        end
        value = $urandom();
        issueIn(5, value);
        issueOut(5);

        // Fill every register, then read all of them back.
        for (int i = 0; i < `DP_NUM_REGS; i++)
            issueIn(datapathPkg::regIdx_t'(i), $urandom());
        for (int i = 0; i < `DP_NUM_REGS; i++)
            issueOut(datapathPkg::regIdx_t'(i));

        foreach (aluOps[i])
        begin
            repeat (2)
            begin
                dest = randomReg();
                issueAlu(aluOps[i], dest, randomReg(), randomReg());
                issueOut(dest);
            end
        end

        // One negative and one positive immediate per operation.
        foreach (immOps[i])
        begin
            value = $urandom();
            imm = value[`DP_IMM_WIDTH-1:0];
            imm[`DP_IMM_WIDTH-1] = 1'b1;
            dest = randomReg();
            issueImm(immOps[i], dest, randomReg(), imm);
            issueOut(dest);
            value = $urandom();
            imm = value[`DP_IMM_WIDTH-1:0];
            imm[`DP_IMM_WIDTH-1] = 1'b0;
            dest = randomReg();
            issueImm(immOps[i], dest, randomReg(), imm);
            issueOut(dest);
        end

        for (int round = 0; round < 3; round++)
        begin
            a = $urandom();
            b = $urandom();
            if (round == 0)
                a = a | 32'h8000_0000;
            issueIn(1, a);
            issueIn(2, b);
            issueMul(1, 2);
            issueMove(datapathPkg::opMfhi, 3);
            issueOut(3);
            issueMove(datapathPkg::opMflo, 4);
            issueOut(4);
        end

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// File: filelist.f
+incdir+hdl
hdl/datapathPkg.sv
hdl/busMux.sv
hdl/instrDecode.sv
hdl/aluExecute.sv
hdl/resultRegs.sv
hdl/datapathTop.sv
tb/datapathTb.sv

// File: Bender.yml
package:
  name: datapath

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/datapathPkg.sv
      - hdl/busMux.sv
      - hdl/instrDecode.sv
      - hdl/aluExecute.sv
      - hdl/resultRegs.sv
      - hdl/datapathTop.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tb/datapathTb.sv
